//--- common/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry

`define DC_ADDR_W 32  // cpu and memory address bits

`define DC_WORD_W 32  // one data word

`define DC_OFF_W 6  // 64 byte line

`define DC_IDX_W 7  // 128 lines

`define DC_TAG_W 19  // addr minus index and offset

// burst shape

`define DC_BEATS 16  // words per line, one beat each

// address map

`define DC_UNC_HI 4'hA  // top nibble of uncached space

`endif

//--- common/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

  typedef struct packed {
    logic [`DC_TAG_W-1:0] tag;
    logic [`DC_IDX_W-1:0] idx;
    logic [`DC_OFF_W-1:0] off;
  } dc_addr_s;

  // flat word for the bus, split view for the arrays
  typedef union packed {
    logic [`DC_ADDR_W-1:0] word;
    dc_addr_s              f;
  } dc_addr_u;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [3:0]            mask;
    logic [3:0]            size;
    dc_addr_u              addr;
    logic [`DC_WORD_W-1:0] wdata;
  } dc_req_s;

  typedef struct packed {
    logic                  valid;
    logic [`DC_ADDR_W-1:0] addr;
    logic [3:0]            size;
    logic [7:0]            len;  // beats minus one
  } dc_rd_req_s;

  typedef struct packed {
    logic                  valid;
    logic [`DC_ADDR_W-1:0] addr;
    logic [3:0]            mask;
    logic [3:0]            size;
    logic [7:0]            len;
    logic [`DC_WORD_W-1:0] data;
  } dc_wr_req_s;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REFILL,
    ST_WRITEBACK,
    ST_UNC_READ,
    ST_UNC_WRITE
  } dc_state_e;

  typedef enum logic [2:0] {
    KIND_NONE,
    KIND_READ_HIT,
    KIND_WRITE_HIT,
    KIND_MISS_CLEAN,
    KIND_MISS_DIRTY,
    KIND_UNC_READ,
    KIND_UNC_WRITE
  } dc_kind_e;

  // what the data array does this cycle
  typedef enum logic [1:0] {
    MODE_WRHIT,
    MODE_REFILL,
    MODE_WBACK
  } dc_mode_e;

endpackage

//--- dcache_ctrl/dcache_ctrl_fsm.sv
`include "dcache_params.svh"

module dcache_ctrl_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  dcache_pkg::dc_req_s    req_i,
  input  dcache_pkg::dc_kind_e   kind_i,
  input  logic [`DC_TAG_W-1:0]   victim_tag_i,
  output logic                   busy_o,
  output logic                   tag_we_o,
  output logic                   dirty_we_o,
  output logic                   data_we_o,
  output dcache_pkg::dc_mode_e   data_mode_o,
  output logic [3:0]             beat_o,
  output logic [`DC_WORD_W-1:0]  data_wdata_o,
  input  logic [`DC_WORD_W-1:0]  wb_word_i,
  input  logic [`DC_WORD_W-1:0]  rd_word_i,
  output logic [`DC_WORD_W-1:0]  rdata_o,
  output logic                   ready_o,
  output dcache_pkg::dc_rd_req_s mem_rd_o,
  input  logic                   mem_rready_i,
  input  logic [`DC_WORD_W-1:0]  mem_rdata_i,
  output dcache_pkg::dc_wr_req_s mem_wr_o,
  input  logic                   mem_wready_i
);
  import dcache_pkg::*;

  localparam logic [3:0] LAST_BEAT = 4'(`DC_BEATS - 1);
  localparam logic [7:0] LINE_LEN  = 8'(`DC_BEATS - 1);
  localparam logic [3:0] LINE_SIZE = 4'b0100;  // 32 bit beats

  dc_state_e             state_q;
  logic [3:0]            beat_q;
  logic                  ready_q;
  logic                  tag_we_q;
  logic                  dirty_q;
  logic                  unc_q;
  logic [`DC_WORD_W-1:0] unc_rdata_q;
  logic                  rd_hs;
  logic                  wr_hs;
  dc_addr_u              line_addr;
  dc_addr_u              victim_addr;

  always_comb begin
    line_addr       = req_i.addr;
    line_addr.f.off = '0;
    victim_addr       = line_addr;
    victim_addr.f.tag = victim_tag_i;  // same index, old tag
  end

  // commands follow the state register, so they hold under stalls
  always_comb begin
    mem_rd_o = '0;
    mem_wr_o = '0;
    unique case (state_q)
      ST_REFILL: begin
        mem_rd_o.valid = 1'b1;
        mem_rd_o.addr  = line_addr.word;
        mem_rd_o.size  = LINE_SIZE;
        mem_rd_o.len   = LINE_LEN;
      end
      ST_WRITEBACK: begin
        mem_wr_o.valid = 1'b1;
        mem_wr_o.addr  = victim_addr.word;
        mem_wr_o.mask  = 4'hf;
        mem_wr_o.size  = LINE_SIZE;
        mem_wr_o.len   = LINE_LEN;
        mem_wr_o.data  = wb_word_i;  // word at beat_q
      end
      ST_UNC_READ: begin
        mem_rd_o.valid = 1'b1;
        mem_rd_o.addr  = req_i.addr.word;
        mem_rd_o.size  = req_i.size;
      end
      ST_UNC_WRITE: begin
        mem_wr_o.valid = 1'b1;
        mem_wr_o.addr  = req_i.addr.word;
        mem_wr_o.mask  = req_i.mask;
        mem_wr_o.size  = req_i.size;
        mem_wr_o.data  = req_i.wdata;
      end
      default: ;
    endcase
  end

  assign rd_hs = mem_rd_o.valid & mem_rready_i;
  assign wr_hs = mem_wr_o.valid & mem_wready_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q  <= ST_IDLE;
      beat_q   <= '0;
      ready_q  <= 1'b0;
      tag_we_q <= 1'b0;
      dirty_q  <= 1'b0;
      unc_q    <= 1'b0;
    end else begin
      ready_q  <= 1'b0;
      tag_we_q <= 1'b0;
      unique case (state_q)
        ST_IDLE: begin
          beat_q <= '0;
          unique case (kind_i)
            KIND_READ_HIT: begin
              ready_q <= 1'b1;
              unc_q   <= 1'b0;
            end
            KIND_WRITE_HIT: begin
              ready_q  <= 1'b1;
              tag_we_q <= 1'b1;
              dirty_q  <= 1'b1;
            end
            KIND_MISS_CLEAN: state_q <= ST_REFILL;
            KIND_MISS_DIRTY: state_q <= ST_WRITEBACK;
            KIND_UNC_READ:   state_q <= ST_UNC_READ;
            KIND_UNC_WRITE:  state_q <= ST_UNC_WRITE;
            default: ;
          endcase
        end
        ST_REFILL: begin
          if (rd_hs) begin
            beat_q <= beat_q + 4'd1;
            if (beat_q == LAST_BEAT) begin
              tag_we_q <= 1'b1;  // line now valid and clean
              dirty_q  <= 1'b0;
              state_q  <= ST_IDLE;
            end
          end
        end
        ST_WRITEBACK: begin
          if (wr_hs) begin
            beat_q <= beat_q + 4'd1;  // wraps to 0 for the refill
            if (beat_q == LAST_BEAT) begin
              state_q <= ST_REFILL;
            end
          end
        end
        ST_UNC_READ: begin
          if (rd_hs) begin
            ready_q <= 1'b1;
            unc_q   <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        ST_UNC_WRITE: begin
          if (wr_hs) begin
            ready_q <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_UNC_READ && rd_hs) begin
      unc_rdata_q <= mem_rdata_i;
    end
  end

  always_comb begin
    data_mode_o = MODE_WRHIT;
    if (state_q == ST_REFILL) begin
      data_mode_o = MODE_REFILL;
    end else if (state_q == ST_WRITEBACK) begin
      data_mode_o = MODE_WBACK;
    end
  end

  assign data_we_o    = (kind_i == KIND_WRITE_HIT) | (state_q == ST_REFILL && rd_hs);
  assign data_wdata_o = (state_q == ST_REFILL) ? mem_rdata_i : req_i.wdata;
  assign beat_o       = beat_q;
  assign tag_we_o     = tag_we_q;
  assign dirty_we_o   = dirty_q;

  // held request must not be decoded again while ready is up
  assign busy_o  = (state_q != ST_IDLE) | tag_we_q | ready_q;
  assign ready_o = ready_q;
  assign rdata_o = unc_q ? unc_rdata_q : rd_word_i;

endmodule

//--- dcache_ctrl/dcache_req_decode.sv
`include "dcache_params.svh"

module dcache_req_decode (
  input  dcache_pkg::dc_req_s  req_i,
  input  logic                 hit_i,
  input  logic                 dirty_i,
  input  logic                 busy_i,
  output dcache_pkg::dc_kind_e kind_o
);
  import dcache_pkg::*;

  logic uncached;

  assign uncached = (req_i.addr.word[`DC_ADDR_W-1 -: 4] == `DC_UNC_HI);

  // busy also covers the tag write after a refill, when the old miss still shows
  always_comb begin
    kind_o = KIND_NONE;
    if (req_i.valid && !busy_i) begin
      if (uncached) begin
        if (req_i.write) begin
          kind_o = KIND_UNC_WRITE;
        end else begin
          kind_o = KIND_UNC_READ;
        end
      end else if (hit_i) begin
        if (req_i.write) begin
          kind_o = KIND_WRITE_HIT;
        end else begin
          kind_o = KIND_READ_HIT;
        end
      end else if (dirty_i) begin
        kind_o = KIND_MISS_DIRTY;  // victim goes out first
      end else begin
        kind_o = KIND_MISS_CLEAN;
      end
    end
  end

endmodule

//--- flist.f
+incdir+common
common/dcache_pkg.sv
dcache_ctrl/dcache_req_decode.sv
dcache_ctrl/dcache_ctrl_fsm.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_checker.sv
test/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f flist.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- test/dcache_checker.sv
module dcache_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   ready_i,
  input dcache_pkg::dc_rd_req_s rd_i,
  input logic                   rready_i,
  input dcache_pkg::dc_wr_req_s wr_i,
  input logic                   wready_i
);

  int fail_count = 0;  // read by the testbench at the end

  reset_quiet: assert property (@(posedge clk) rst |-> !rd_i.valid && !wr_i.valid)
    else begin
      fail_count++;
      $error("memory valid high while in reset");
    end

  ready_pulse: assert property (@(posedge clk) disable iff (rst) ready_i |=> !ready_i)
    else begin
      fail_count++;
      $error("ready_o high for two cycles");
    end

  one_channel: assert property (@(posedge clk) disable iff (rst) !(rd_i.valid && wr_i.valid))
    else begin
      fail_count++;
      $error("read and write valid high together");
    end

  // stalled beat keeps its command
  rd_hold: assert property (@(posedge clk) disable iff (rst)
    rd_i.valid && !rready_i |=> rd_i.valid && $stable(rd_i.addr) && $stable(rd_i.len))
    else begin
      fail_count++;
      $error("read command changed before its handshake");
    end

  wr_hold: assert property (@(posedge clk) disable iff (rst)
    wr_i.valid && !wready_i |=> wr_i.valid && $stable(wr_i.addr) && $stable(wr_i.data))
    else begin
      fail_count++;
      $error("write command changed before its handshake");
    end

endmodule

bind dcache_top dcache_checker u_checker (
  .clk      (clk),
  .rst      (rst),
  .ready_i  (ready_o),
  .rd_i     (mem_rd_o),
  .rready_i (mem_rready_i),
  .wr_i     (mem_wr_o),
  .wready_i (mem_wready_i)
);

//--- test/dcache_mem_model.sv
`include "dcache_params.svh"

module dcache_mem_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_en_i,
  input  dcache_pkg::dc_rd_req_s rd_i,
  output logic                   rready_o,
  output logic [`DC_WORD_W-1:0]  rdata_o,
  input  dcache_pkg::dc_wr_req_s wr_i,
  output logic                   wready_o
);

  logic [`DC_WORD_W-1:0] shadow [logic [`DC_ADDR_W-1:0]];  // sparse, untouched words keep seed
  logic [15:0]           lfsr;
  logic [15:0]           lfsr_mid;
  logic [15:0]           lfsr_nxt;
  logic [7:0]            rd_beat;
  logic [7:0]            wr_beat;
  logic [`DC_ADDR_W-1:0] wr_addr;

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [`DC_ADDR_W-1:0] beat_addr(input logic [`DC_ADDR_W-1:0] base,
                                                     input logic [7:0] beat);
    return {base[`DC_ADDR_W-1:2], 2'b00} + {22'd0, beat, 2'b00};
  endfunction

  function automatic logic [`DC_WORD_W-1:0] peek(input logic [`DC_ADDR_W-1:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return a ^ 32'h5a5a_5a5a;
  endfunction

  function automatic logic [`DC_WORD_W-1:0] merge_bytes(input logic [`DC_WORD_W-1:0] old,
                                                       input logic [`DC_WORD_W-1:0] data,
                                                       input logic [3:0] mask);
    logic [`DC_WORD_W-1:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        w[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return w;
  endfunction

  assign lfsr_mid = lfsr_step(lfsr);
  assign lfsr_nxt = lfsr_step(lfsr_mid);
  assign wr_addr  = beat_addr(wr_i.addr, wr_beat);

  // ready and read data change on the falling edge
  always @(negedge clk or posedge rst) begin
    if (rst) begin
      lfsr     <= 16'h0001;
      rready_o <= 1'b0;
      wready_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      lfsr     <= lfsr_nxt;
      rready_o <= !stall_en_i || lfsr_mid[0];
      wready_o <= !stall_en_i || lfsr_nxt[0];
      rdata_o  <= peek(beat_addr(rd_i.addr, rd_beat));
    end
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      shadow.delete();
      rd_beat <= '0;
      wr_beat <= '0;
    end else begin
      if (rd_i.valid && rready_o) begin
        rd_beat <= (rd_beat == rd_i.len) ? 8'd0 : rd_beat + 8'd1;
      end
      if (wr_i.valid && wready_o) begin
        shadow[wr_addr] = merge_bytes(peek(wr_addr), wr_i.data, wr_i.mask);
        wr_beat <= (wr_beat == wr_i.len) ? 8'd0 : wr_beat + 8'd1;
      end
    end
  end

endmodule

//--- test/dcache_tb.sv
`include "dcache_params.svh"

module dcache_tb;
  import dcache_pkg::*;

  localparam int NUM_ENTRIES  = 13;
  localparam int PASSES       = 2;  // second pass with ready stalls
  localparam int RESET_CYCLES = 5;
  localparam int CYCLE_LIMIT  = PASSES * (NUM_ENTRIES * 80 + RESET_CYCLES + 2);

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [3:0]  mask;
    logic [31:0] data;
    logic [31:0] exp_rdata;
    logic [31:0] rd_beats;
    logic [31:0] rd_addr;
    logic [31:0] wr_beats;
    logic [31:0] wr_addr;
  } entry_s;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  stall_en;
  dc_req_s               req;
  logic [`DC_WORD_W-1:0] rdata;
  logic                  ready;
  dc_rd_req_s            mem_rd;
  logic                  mem_rready;
  logic [`DC_WORD_W-1:0] mem_rdata;
  dc_wr_req_s            mem_wr;
  logic                  mem_wready;
  entry_s                stim [NUM_ENTRIES];
  logic [31:0]           cpu_view [logic [31:0]];  // what the cpu should see per word
  int                    errors = 0;
  int                    wb_errors = 0;
  int                    cycles = 0;
  logic [31:0]           rd_total = '0;
  logic [31:0]           wr_total = '0;
  logic [31:0]           rd_vcyc = '0;
  logic [31:0]           rd_addr_q;
  logic [31:0]           wr_addr_q;
  logic [7:0]            rd_len_q;
  logic [7:0]            wr_len_q;
  logic [3:0]            rd_size_q;
  logic [3:0]            wr_size_q;
  logic [3:0]            wr_mask_q;
  logic [7:0]            wb_beat;

  dcache_top u_dcache_top (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req),
    .rdata_o      (rdata),
    .ready_o      (ready),
    .mem_rd_o     (mem_rd),
    .mem_rready_i (mem_rready),
    .mem_rdata_i  (mem_rdata),
    .mem_wr_o     (mem_wr),
    .mem_wready_i (mem_wready)
  );

  dcache_mem_model u_mem_model (
    .clk        (clk),
    .rst        (rst),
    .stall_en_i (stall_en),
    .rd_i       (mem_rd),
    .rready_o   (mem_rready),
    .rdata_o    (mem_rdata),
    .wr_i       (mem_wr),
    .wready_o   (mem_wready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] init_word(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_5a5a;
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] mask);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        w[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return w;
  endfunction

  function automatic logic [31:0] view_word(input logic [31:0] a);
    if (cpu_view.exists({a[31:2], 2'b00})) begin
      return cpu_view[{a[31:2], 2'b00}];
    end
    return init_word(a);
  endfunction

  function automatic entry_s make_entry(input logic w, input logic [31:0] a, input logic [3:0] m,
                                        input logic [31:0] d, input logic [31:0] exp,
                                        input logic [31:0] rb, input logic [31:0] ra,
                                        input logic [31:0] wb, input logic [31:0] wa);
    return '{w, a, m, d, exp, rb, ra, wb, wa};
  endfunction

  // index 0x41 for lines 0x1040/0x3040, index 0x40 for 0x5000/0x7000
  task automatic fill_stimulus();
    logic [31:0] merged;
    logic [31:0] unc_merged;
    merged     = merge_word(init_word(32'h1048), 32'hdead_beef, 4'b0101);
    unc_merged = merge_word(init_word(32'ha000_0010), 32'hcafe_f00d, 4'b0011);
    stim[0]  = make_entry(1'b0, 32'h1048, 4'h0, '0, init_word(32'h1048), 16, 32'h1040, 0, '0);
    stim[1]  = make_entry(1'b0, 32'h107c, 4'h0, '0, init_word(32'h107c), 0, '0, 0, '0);
    stim[2]  = make_entry(1'b1, 32'h1048, 4'b0101, 32'hdead_beef, '0, 0, '0, 0, '0);
    stim[3]  = make_entry(1'b0, 32'h1048, 4'h0, '0, merged, 0, '0, 0, '0);
    stim[4]  = make_entry(1'b0, 32'h3048, 4'h0, '0, init_word(32'h3048), 16, 32'h3040,
                          16, 32'h1040);
    stim[5]  = make_entry(1'b0, 32'h1048, 4'h0, '0, merged, 16, 32'h1040, 0, '0);
    stim[6]  = make_entry(1'b1, 32'h5004, 4'hf, 32'h1234_5678, '0, 16, 32'h5000, 0, '0);
    stim[7]  = make_entry(1'b0, 32'h5004, 4'h0, '0, 32'h1234_5678, 0, '0, 0, '0);
    stim[8]  = make_entry(1'b0, 32'ha000_0010, 4'h0, '0, init_word(32'ha000_0010),
                          1, 32'ha000_0010, 0, '0);
    stim[9]  = make_entry(1'b1, 32'ha000_0010, 4'b0011, 32'hcafe_f00d, '0, 0, '0,
                          1, 32'ha000_0010);
    stim[10] = make_entry(1'b0, 32'ha000_0010, 4'h0, '0, unc_merged, 1, 32'ha000_0010, 0, '0);
    stim[11] = make_entry(1'b0, 32'h7004, 4'h0, '0, init_word(32'h7004), 16, 32'h7000,
                          16, 32'h5000);
    stim[12] = make_entry(1'b0, 32'h5004, 4'h0, '0, 32'h1234_5678, 16, 32'h5000, 0, '0);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH at %0t: %s got %08h expected %08h", $time, name, got, exp);
    errors++;
  endtask

  task automatic run_reset();
    req.valid = 1'b0;
    rst = 1'b1;
    cpu_view.delete();  // memory model starts over too
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    repeat (2) begin
      @(negedge clk);
      assert (!ready && !mem_rd.valid && !mem_wr.valid) else begin
        $display("cache is not idle after reset: ready or a memory valid is high");
        errors++;
      end
    end
  endtask

  task automatic apply_entry(input entry_s e);
    logic [31:0] rd_start;
    logic [31:0] wr_start;
    logic [31:0] rd_v_start;
    logic [3:0]  exp_wmask;
    rd_start     = rd_total;
    wr_start     = wr_total;
    rd_v_start   = rd_vcyc;
    exp_wmask    = (e.wr_beats == 32'd1) ? e.mask : 4'hf;  // line beats carry whole words
    req.valid    = 1'b1;
    req.write    = e.write;
    req.mask     = e.mask;
    req.size     = 4'h4;
    req.addr     = e.addr;
    req.wdata    = e.data;
    do begin
      @(negedge clk);
    end while (!ready);
    if (e.write) begin
      cpu_view[{e.addr[31:2], 2'b00}] = merge_word(view_word(e.addr), e.data, e.mask);
    end else begin
      assert (rdata == e.exp_rdata) else report_mismatch("rdata_o", rdata, e.exp_rdata);
    end
    assert (rd_total - rd_start == e.rd_beats)
      else report_mismatch("read beats", rd_total - rd_start, e.rd_beats);
    assert (wr_total - wr_start == e.wr_beats)
      else report_mismatch("write beats", wr_total - wr_start, e.wr_beats);
    if (e.rd_beats == 0) begin
      assert (rd_vcyc == rd_v_start) else begin
        $display("memory read valid went high for a request that should not read");
        errors++;
      end
    end else begin
      assert (rd_addr_q == e.rd_addr) else report_mismatch("mem_rd_o.addr", rd_addr_q, e.rd_addr);
      assert (rd_len_q == 8'(e.rd_beats - 32'd1))
        else report_mismatch("mem_rd_o.len", 32'(rd_len_q), e.rd_beats - 32'd1);
      if (e.rd_beats == 32'd1) begin
        assert (rd_size_q == req.size)
          else report_mismatch("mem_rd_o.size", 32'(rd_size_q), 32'(req.size));
      end
    end
    if (e.wr_beats != 0) begin
      assert (wr_addr_q == e.wr_addr) else report_mismatch("mem_wr_o.addr", wr_addr_q, e.wr_addr);
      assert (wr_len_q == 8'(e.wr_beats - 32'd1))
        else report_mismatch("mem_wr_o.len", 32'(wr_len_q), e.wr_beats - 32'd1);
      assert (wr_mask_q == exp_wmask)
        else report_mismatch("mem_wr_o.mask", 32'(wr_mask_q), 32'(exp_wmask));
      if (e.wr_beats == 32'd1) begin
        assert (wr_size_q == req.size)
          else report_mismatch("mem_wr_o.size", 32'(wr_size_q), 32'(req.size));
      end
    end
    @(negedge clk);  // request held through the ready cycle
  endtask

  // memory port monitor and run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (mem_rd.valid) begin
      rd_vcyc <= rd_vcyc + 32'd1;
    end
    if (mem_rd.valid && mem_rready) begin
      rd_total  <= rd_total + 32'd1;
      rd_addr_q <= mem_rd.addr;
      rd_len_q  <= mem_rd.len;
      rd_size_q <= mem_rd.size;
    end
    if (rst) begin
      wb_beat <= '0;
    end else if (mem_wr.valid && mem_wready) begin
      wr_total  <= wr_total + 32'd1;
      wr_addr_q <= mem_wr.addr;
      wr_len_q  <= mem_wr.len;
      wr_size_q <= mem_wr.size;
      wr_mask_q <= mem_wr.mask;
      wb_beat   <= (wb_beat == mem_wr.len) ? 8'd0 : wb_beat + 8'd1;
      if (mem_wr.len != 8'd0) begin
        assert (mem_wr.data == view_word(mem_wr.addr + {22'd0, wb_beat, 2'b00})) else begin
          $display("MISMATCH at %0t: mem_wr_o.data got %08h expected %08h", $time, mem_wr.data,
                   view_word(mem_wr.addr + {22'd0, wb_beat, 2'b00}));
          wb_errors <= wb_errors + 1;
        end
      end
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped, no finish within %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    rst      = 1'b1;
    req      = '0;
    stall_en = 1'b0;
    fill_stimulus();
    for (int p = 0; p < PASSES; p++) begin
      stall_en = (p == 1);
      run_reset();
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        apply_entry(stim[i]);
      end
      req.valid = 1'b0;
    end
    $display("errors: %0d request checks, %0d write-back beats, %0d protocol assertions",
             errors, wb_errors, u_dcache_top.u_checker.fail_count);
    if (errors == 0 && wb_errors == 0 && u_dcache_top.u_checker.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verilog/dcache_data_store.sv
`include "dcache_params.svh"

module dcache_data_store (
  input  logic                  clk,
  input  logic [`DC_IDX_W-1:0]  index_i,
  input  logic [`DC_OFF_W-3:0]  offset_i,
  input  logic [3:0]            beat_i,
  input  dcache_pkg::dc_mode_e  mode_i,
  input  logic                  we_i,
  input  logic [3:0]            mask_i,
  input  logic [`DC_WORD_W-1:0] wdata_i,
  output logic [`DC_WORD_W-1:0] rdata_o,
  output logic [`DC_WORD_W-1:0] wb_word_o
);
  import dcache_pkg::*;

  localparam int LINES = 1 << `DC_IDX_W;

  logic [`DC_WORD_W-1:0] line_mem [LINES][`DC_BEATS];
  logic                  wr_en;
  logic [3:0]            wsel;
  logic [3:0]            wbe;

  always_comb begin
    wr_en = we_i;
    wsel  = offset_i;
    wbe   = mask_i;
    unique case (mode_i)
      MODE_REFILL: begin
        wsel = beat_i;  // whole word per beat
        wbe  = 4'hf;
      end
      MODE_WBACK: begin
        wr_en = 1'b0;  // line is being drained
      end
      default: ;
    endcase
  end

  // byte merge, untouched lanes keep their old value
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wbe[b]) begin
          line_mem[index_i][wsel][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign rdata_o   = line_mem[index_i][offset_i];
  assign wb_word_o = line_mem[index_i][beat_i];

endmodule

//--- verilog/dcache_tag_store.sv
`include "dcache_params.svh"

module dcache_tag_store (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`DC_IDX_W-1:0] index_i,
  input  logic [`DC_TAG_W-1:0] tag_i,
  input  logic                 we_i,
  input  logic                 dirty_i,
  output logic                 hit_o,
  output logic                 dirty_o,
  output logic [`DC_TAG_W-1:0] tag_o
);

  localparam int LINES = 1 << `DC_IDX_W;

  logic [LINES-1:0]     valid_q;
  logic [LINES-1:0]     dirty_q;
  logic [`DC_TAG_W-1:0] tag_mem [LINES];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (we_i) begin
      valid_q[index_i] <= 1'b1;
      dirty_q[index_i] <= dirty_i;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  assign tag_o   = tag_mem[index_i];
  assign hit_o   = valid_q[index_i] && (tag_o == tag_i);
  assign dirty_o = valid_q[index_i] && dirty_q[index_i];  // invalid line never written back

endmodule

//--- verilog/dcache_top.sv
`include "dcache_params.svh"

module dcache_top (
  input  logic                   clk,
  input  logic                   rst,
  input  dcache_pkg::dc_req_s    req_i,
  output logic [`DC_WORD_W-1:0]  rdata_o,
  output logic                   ready_o,
  output dcache_pkg::dc_rd_req_s mem_rd_o,
  input  logic                   mem_rready_i,
  input  logic [`DC_WORD_W-1:0]  mem_rdata_i,
  output dcache_pkg::dc_wr_req_s mem_wr_o,
  input  logic                   mem_wready_i
);
  import dcache_pkg::*;

  logic                  hit;
  logic                  dirty;
  logic [`DC_TAG_W-1:0]  stored_tag;
  logic                  busy;
  dc_kind_e              kind;
  logic                  tag_we;
  logic                  dirty_val;
  logic                  data_we;
  dc_mode_e              data_mode;
  logic [3:0]            beat;
  logic [`DC_WORD_W-1:0] data_wdata;
  logic [`DC_WORD_W-1:0] rd_word;
  logic [`DC_WORD_W-1:0] wb_word;

  dcache_req_decode u_req_decode (
    .req_i   (req_i),
    .hit_i   (hit),
    .dirty_i (dirty),
    .busy_i  (busy),
    .kind_o  (kind)
  );

  dcache_ctrl_fsm u_ctrl_fsm (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .kind_i       (kind),
    .victim_tag_i (stored_tag),
    .busy_o       (busy),
    .tag_we_o     (tag_we),
    .dirty_we_o   (dirty_val),
    .data_we_o    (data_we),
    .data_mode_o  (data_mode),
    .beat_o       (beat),
    .data_wdata_o (data_wdata),
    .wb_word_i    (wb_word),
    .rd_word_i    (rd_word),
    .rdata_o      (rdata_o),
    .ready_o      (ready_o),
    .mem_rd_o     (mem_rd_o),
    .mem_rready_i (mem_rready_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_wr_o     (mem_wr_o),
    .mem_wready_i (mem_wready_i)
  );

  dcache_tag_store u_tag_store (
    .clk     (clk),
    .rst     (rst),
    .index_i (req_i.addr.f.idx),
    .tag_i   (req_i.addr.f.tag),
    .we_i    (tag_we),
    .dirty_i (dirty_val),
    .hit_o   (hit),
    .dirty_o (dirty),
    .tag_o   (stored_tag)
  );

  dcache_data_store u_data_store (
    .clk       (clk),
    .index_i   (req_i.addr.f.idx),
    .offset_i  (req_i.addr.f.off[`DC_OFF_W-1:2]),  // word within line
    .beat_i    (beat),
    .mode_i    (data_mode),
    .we_i      (data_we),
    .mask_i    (req_i.mask),
    .wdata_i   (data_wdata),
    .rdata_o   (rd_word),
    .wb_word_o (wb_word)
  );

endmodule
